// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0
TOP       ?= tb_hist_saxi
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := all tests passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: build.f
+incdir+.
hist_pkg.sv
hist_fifo.sv
hist_regs.sv
hist_arbiter.sv
hist_page_writer.sv
hist_page_buffer.sv
hist_axi_sender.sv
hist_saxi_top.sv
tb_hist_saxi.sv

// File: hist_arbiter.sv
// fixed priority arbiter for the four sensor sources, source 0 wins
// grant is held until the page writer reports page end, the granted
// source's stream is registered once and passed to the writer
`timescale 1ns/1ps
`default_nettype none
`include "hist_defs.svh"

module hist_arbiter (
    input  wire                        mclk,
    input  wire                        nreset_aclk,
    input  wire                        en,
    input  wire hist_pkg::hist_src_t   src [`HIST_NUM_SRC],
    input  wire                        buf_full,
    input  wire                        page_done,
    output logic [`HIST_NUM_SRC-1:0]   grant,
    output hist_pkg::hist_src_t        sel_src,
    output logic [`HIST_SRC_W-1:0]     sel_idx
);
    logic                   rq_any;     // any request this cycle
    logic [`HIST_SRC_W-1:0] rq_idx;     // lowest requesting index
    logic                   rq_any_r;
    logic [`HIST_SRC_W-1:0] rq_idx_r;
    logic                   busy;       // a page is being received

    always_comb begin
        rq_any = 1'b0;
        rq_idx = '0;
        for (int i = `HIST_NUM_SRC - 1; i >= 0; i--) begin   // last hit is the lowest index
            if (src[i].request) begin
                rq_any = 1'b1;
                rq_idx = i[`HIST_SRC_W-1:0];
            end
        end
    end

    always_ff @(posedge mclk) begin
        if (!nreset_aclk || !en) begin
            rq_any_r <= 1'b0;
            rq_idx_r <= '0;
            busy     <= 1'b0;
            grant    <= '0;
            sel_idx  <= '0;
        end else begin
            rq_any_r <= rq_any;
            rq_idx_r <= rq_idx;
            if (page_done) begin
                busy  <= 1'b0;
                grant <= '0;
            end else if (!busy && rq_any_r && !buf_full) begin
                busy    <= 1'b1;
                sel_idx <= rq_idx_r;            // latched for the whole page
                grant   <= `HIST_NUM_SRC'(1) << rq_idx_r;
            end
        end
    end

    // one-cycle registered mux, dvalid only counts while granted
    always_ff @(posedge mclk) begin
        if (!nreset_aclk || !en) begin
            sel_src <= '0;
        end else begin
            sel_src        <= src[sel_idx];
            sel_src.dvalid <= busy && src[sel_idx].dvalid;
        end
    end

endmodule

`default_nettype wire

// File: hist_axi_sender.sv
// sends finished pages over the AXI write address and data channels
// one block per page: attribute pop, two-step base address, sixteen bursts,
// page read into a small read-ahead FIFO, page freed at block end
`timescale 1ns/1ps
`default_nettype none
`include "hist_defs.svh"

module hist_axi_sender (
    input  wire                           mclk,
    input  wire                           nreset_aclk,
    input  wire hist_pkg::hist_mode_t     mode,
    input  wire [`HIST_START_PAGE_W-1:0]  start_page [`HIST_NUM_SRC],
    input  wire [2:0]                     pages_used,
    input  wire hist_pkg::hist_attr_t     attr,
    input  wire                           attr_nempty,
    output logic                          attr_pop,
    output logic                          rd_en,
    output logic [9:0]                    rd_addr,
    input  wire [`HIST_WORD_W-1:0]        rd_data,
    output logic                          page_freed,
    output hist_pkg::axi_aw_t             aw,
    output logic                          awvalid,
    input  wire                           awready,
    output hist_pkg::axi_w_t              w,
    output logic                          wvalid,
    input  wire                           wready,
    input  wire                           bvalid
);
    import hist_pkg::*;

    localparam int NB   = `HIST_PAGE_WORDS / `HIST_BURST_LEN;  // bursts per page
    localparam int BC_W = $clog2(NB) + 1;
    localparam int PW   = `HIST_START_PAGE_W;
    localparam int WA_W = $clog2(`HIST_PAGE_WORDS);
    localparam int PG_W = $clog2(`HIST_NUM_PAGES);

    hist_attr_t                        attr_r;      // page being sent
    logic                              confirm_r;   // mode latched per block
    logic                              block_run;
    logic [2:0]                        start_r;     // start pipeline
    logic [PW-1:0]                     page_base;   // looked-up start page
    logic [31:0]                       aw_addr;
    logic [BC_W-1:0]                   aw_left;     // bursts still to address
    logic [BC_W-1:0]                   w_left;      // bursts still to send data
    logic [7:0]                        b_pend;      // responses outstanding
    logic [PG_W-1:0]                   page_rd;
    logic [WA_W-1:0]                   rd_word;
    logic                              rd_run;
    logic [1:0]                        rd_v;        // reads in flight
    logic                              fifo_half;
    logic [`HIST_WORD_W-1:0]           w_data;
    logic [$clog2(`HIST_BURST_LEN)-1:0] wcnt;       // word in burst
    logic                              aw_xfer;
    logic                              w_xfer;
    logic                              block_end;

    assign attr_pop   = mode.en && !block_run && (pages_used != '0) && attr_nempty;
    assign aw_xfer    = awvalid && awready;
    assign w_xfer     = wvalid && wready;
    assign awvalid    = (aw_left != '0);
    assign aw         = '{addr: aw_addr, id: {attr_r.src, attr_r.color}};
    assign w          = '{data: w_data, last: &wcnt};
    assign rd_en      = rd_run && !fifo_half;           // at most 3 reads in flight
    assign rd_addr    = {page_rd, rd_word};
    assign block_end  = block_run && (start_r == '0) && (aw_left == '0) && (w_left == '0) &&
                        (!confirm_r || b_pend == '0);
    assign page_freed = block_end;

    always_ff @(posedge mclk) begin
        if (!nreset_aclk || !mode.en) begin
            block_run <= 1'b0;
            start_r   <= '0;
            aw_left   <= '0;
            w_left    <= '0;
            b_pend    <= '0;
            page_rd   <= '0;
            rd_word   <= '0;
            rd_run    <= 1'b0;
            rd_v      <= '0;
            wcnt      <= '0;
        end else begin
            start_r <= {start_r[1:0], attr_pop};
            if (attr_pop)       block_run <= 1'b1;
            else if (block_end) block_run <= 1'b0;
            if (block_end) page_rd <= page_rd + 1'b1;   // pages leave in arrival order
            if (start_r[2])   aw_left <= BC_W'(NB);     // base address ready
            else if (aw_xfer) aw_left <= aw_left - 1'b1;
            if (attr_pop)            w_left <= BC_W'(NB);
            else if (w_xfer && w.last) w_left <= w_left - 1'b1;
            if (aw_xfer && !bvalid)                    b_pend <= b_pend + 8'd1;
            else if (!aw_xfer && bvalid && b_pend != '0) b_pend <= b_pend - 8'd1;
            if (attr_pop)   rd_word <= '0;
            else if (rd_en) rd_word <= rd_word + 1'b1;
            if (attr_pop)                  rd_run <= 1'b1;
            else if (rd_en && (&rd_word))  rd_run <= 1'b0;   // last word of the page
            rd_v <= {rd_v[0], rd_en};
            if (w_xfer) wcnt <= wcnt + 1'b1;
        end
    end

    always_ff @(posedge mclk) begin
        if (attr_pop) begin
            attr_r    <= attr;
            confirm_r <= mode.confirm;
        end
        if (start_r[0]) page_base <= start_page[attr_r.src];
        if (start_r[1])   aw_addr <= {page_base + PW'(attr_r.frame), attr_r.color, 10'd0};
        else if (aw_xfer) aw_addr <= aw_addr + 32'(`HIST_BURST_LEN * 4);
    end

    hist_fifo #(
        .T     (logic [`HIST_WORD_W-1:0]),
        .DEPTH (4)
    ) rd_fifo_i (
        .mclk        (mclk),
        .nreset_aclk (nreset_aclk),
        .clear       (!mode.en),
        .push        (rd_v[1]),     // buffer data valid
        .din         (rd_data),
        .pop         (w_xfer),
        .dout        (w_data),
        .nempty      (wvalid),
        .half_full   (fifo_half)
    );

endmodule

`default_nettype wire

// File: hist_defs.svh
// sizes, widths and register map of the histogram transfer block
// included by the package and by every module that needs a width
`ifndef HIST_DEFS_SVH
`define HIST_DEFS_SVH

`define HIST_WORD_W        32    // histogram word
`define HIST_NUM_SRC       4     // sensor sources
`define HIST_SRC_W         2     // source index
`define HIST_FRAME_W       4     // frame number bits
`define HIST_PAGE_WORDS    256   // words per histogram page
`define HIST_NUM_PAGES     4     // pages in the buffer
`define HIST_BURST_LEN     16    // words per AXI burst
`define HIST_START_PAGE_W  20    // start page in 4 KB units
`define HIST_REG_ADDR_W    4     // register port address
`define HIST_REG_MODE      4     // mode register
`define HIST_REG_START0    0     // start page of source 0, sources follow
`define HIST_MODE_EN       0     // mode bit, transfer enable
`define HIST_MODE_CONFIRM  1     // mode bit, wait for write responses

`endif

// File: hist_fifo.sv
// small synchronous FIFO, show-ahead output, payload type set by parameter
// holds page attributes and the sender's read-ahead words
`timescale 1ns/1ps
`default_nettype none

module hist_fifo #(
    parameter type T     = logic [31:0],
    parameter int  DEPTH = 4                // power of two
) (
    input  wire  mclk,
    input  wire  nreset_aclk,
    input  wire  clear,                     // sync flush
    input  wire  push,
    input  wire  T din,
    input  wire  pop,
    output T     dout,
    output logic nempty,
    output logic half_full
);
    localparam int AW = $clog2(DEPTH);
    localparam int CW = AW + 1;

    T              mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;

    always_ff @(posedge mclk) begin
        if (push) mem[wr_ptr] <= din;
    end

    always_ff @(posedge mclk) begin
        if (!nreset_aclk || clear) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;      // wraps with the power-of-two depth
            if (pop)  rd_ptr <= rd_ptr + 1'b1;
            count <= count + CW'(push) - CW'(pop);
        end
    end

    assign dout      = mem[rd_ptr];
    assign nempty    = (count != '0);
    assign half_full = (count >= CW'(DEPTH / 2));

endmodule

`default_nettype wire

// File: hist_page_buffer.sv
// four-page word memory between the source side and the AXI sender
// read data appears two cycles after rd_en, pages_used counts full pages
`timescale 1ns/1ps
`default_nettype none
`include "hist_defs.svh"

module hist_page_buffer (
    input  wire                       mclk,
    input  wire                       nreset_aclk,
    input  wire                       en,
    input  wire                       wr_en,
    input  wire [9:0]                 wr_addr,
    input  wire [`HIST_WORD_W-1:0]    wr_data,
    input  wire                       page_done,   // one page written
    input  wire                       page_freed,  // one page sent
    input  wire                       rd_en,
    input  wire [9:0]                 rd_addr,
    output logic [`HIST_WORD_W-1:0]   rd_data,
    output logic [2:0]                pages_used,
    output logic                      buf_full
);
    logic [`HIST_WORD_W-1:0] mem [`HIST_NUM_PAGES * `HIST_PAGE_WORDS];
    logic [`HIST_WORD_W-1:0] rd_q;      // first read stage
    logic                    rd_en_r;   // output register enable

    always_ff @(posedge mclk) begin
        if (wr_en)   mem[wr_addr] <= wr_data;
        if (rd_en)   rd_q         <= mem[rd_addr];
        if (rd_en_r) rd_data      <= rd_q;
    end

    always_ff @(posedge mclk) begin
        if (!nreset_aclk || !en) begin
            rd_en_r    <= 1'b0;
            pages_used <= '0;
        end else begin
            rd_en_r <= rd_en;
            if (page_done && !page_freed)      pages_used <= pages_used + 3'd1;
            else if (!page_done && page_freed) pages_used <= pages_used - 3'd1;
        end
    end

    assign buf_full = (pages_used == 3'(`HIST_NUM_PAGES));

endmodule

`default_nettype wire

// File: hist_page_writer.sv
// writes the granted stream into the page buffer word by word
// page ends on the first idle cycle after data, the attribute of a page
// is pushed together with its first word
`timescale 1ns/1ps
`default_nettype none
`include "hist_defs.svh"

module hist_page_writer (
    input  wire                        mclk,
    input  wire                        nreset_aclk,
    input  wire                        en,
    input  wire hist_pkg::hist_src_t   sel_src,
    input  wire [`HIST_SRC_W-1:0]      sel_idx,
    output logic                       wr_en,
    output logic [9:0]                 wr_addr,
    output logic [`HIST_WORD_W-1:0]    wr_data,
    output logic                       page_done,
    output logic                       attr_push,
    output hist_pkg::hist_attr_t       attr
);
    localparam int WA_W = $clog2(`HIST_PAGE_WORDS);
    localparam int PG_W = $clog2(`HIST_NUM_PAGES);

    logic [PG_W-1:0] page_wr;           // page being filled
    logic [WA_W-1:0] page_wa;           // word within the page
    logic            dvalid_r;

    assign wr_en     = sel_src.dvalid;
    assign wr_data   = sel_src.data;
    assign wr_addr   = {page_wr, page_wa};
    assign attr_push = sel_src.dvalid && !dvalid_r;     // first word of the page
    assign attr      = '{src: sel_idx, color: sel_src.color, frame: sel_src.frame};

    always_ff @(posedge mclk) begin
        if (!nreset_aclk || !en) begin
            dvalid_r  <= 1'b0;
            page_wa   <= '0;
            page_wr   <= '0;
            page_done <= 1'b0;
        end else begin
            dvalid_r  <= sel_src.dvalid;
            page_wa   <= sel_src.dvalid ? page_wa + 1'b1 : '0;
            page_done <= dvalid_r && !sel_src.dvalid;    // falling edge of dvalid
            if (dvalid_r && !sel_src.dvalid)
                page_wr <= page_wr + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: hist_pkg.sv
// packed types shared by the histogram transfer modules
// modules use scoped names in ports and import the package in the body
`default_nettype none
`include "hist_defs.svh"

package hist_pkg;

    typedef struct packed {
        logic                       request;  // held until grant
        logic [1:0]                 color;
        logic [`HIST_FRAME_W-1:0]   frame;
        logic                       dvalid;   // one word per cycle while high
        logic [`HIST_WORD_W-1:0]    data;
    } hist_src_t;

    typedef struct packed {
        logic [`HIST_SRC_W-1:0]     src;
        logic [1:0]                 color;
        logic [`HIST_FRAME_W-1:0]   frame;
    } hist_attr_t;

    typedef struct packed {
        logic                       valid;
        logic [`HIST_REG_ADDR_W-1:0] addr;
        logic [31:0]                data;
    } reg_wr_t;

    typedef struct packed {
        logic en;
        logic confirm;
    } hist_mode_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [3:0]  id;        // {source, color}
    } axi_aw_t;

    typedef struct packed {
        logic [`HIST_WORD_W-1:0] data;
        logic                    last;
    } axi_w_t;

endpackage

`default_nettype wire

// File: hist_regs.sv
// host register file: mode bits and per-source start page table
// a write on reg_wr shows on the outputs after the next clock edge
`timescale 1ns/1ps
`default_nettype none
`include "hist_defs.svh"

module hist_regs (
    input  wire                           mclk,
    input  wire                           nreset_aclk,
    input  wire hist_pkg::reg_wr_t        reg_wr,
    output hist_pkg::hist_mode_t          mode,
    output logic [`HIST_START_PAGE_W-1:0] start_page [`HIST_NUM_SRC]
);
    localparam int SW = `HIST_SRC_W;

    always_ff @(posedge mclk) begin
        if (!nreset_aclk) begin
            mode <= '0;                             // disabled, no confirm
        end else if (reg_wr.valid && reg_wr.addr == `HIST_REG_MODE) begin
            mode.en      <= reg_wr.data[`HIST_MODE_EN];
            mode.confirm <= reg_wr.data[`HIST_MODE_CONFIRM];
        end
    end

    // table has no reset, host loads it before enabling
    always_ff @(posedge mclk) begin
        if (reg_wr.valid && reg_wr.addr < `HIST_REG_START0 + `HIST_NUM_SRC)
            start_page[SW'(reg_wr.addr - `HIST_REG_START0)] <=
                reg_wr.data[`HIST_START_PAGE_W-1:0];
    end

endmodule

`default_nettype wire

// File: hist_saxi_top.sv
// histogram pages from four sensor sources to memory over AXI writes
// connects registers, arbiter, page writer, buffer and AXI sender
`timescale 1ns/1ps
`default_nettype none
`include "hist_defs.svh"

module hist_saxi_top (
    input  wire                       mclk,
    input  wire                       nreset_aclk,
    input  wire hist_pkg::reg_wr_t    reg_wr,
    input  wire hist_pkg::hist_src_t  src [`HIST_NUM_SRC],
    output logic [`HIST_NUM_SRC-1:0]  grant,
    output hist_pkg::axi_aw_t         aw,
    output logic                      awvalid,
    input  wire                       awready,
    output hist_pkg::axi_w_t          w,
    output logic                      wvalid,
    input  wire                       wready,
    input  wire                       bvalid
);
    import hist_pkg::*;

    hist_mode_t                    mode;
    logic [`HIST_START_PAGE_W-1:0] start_page [`HIST_NUM_SRC];
    hist_src_t                     sel_src;
    logic [`HIST_SRC_W-1:0]        sel_idx;
    logic                          wr_en;
    logic [9:0]                    wr_addr;
    logic [`HIST_WORD_W-1:0]       wr_data;
    logic                          page_done;
    logic                          attr_push;
    hist_attr_t                    attr_in;
    hist_attr_t                    attr_out;
    logic                          attr_nempty;
    logic                          attr_pop;
    logic                          rd_en;
    logic [9:0]                    rd_addr;
    logic [`HIST_WORD_W-1:0]       rd_data;
    logic [2:0]                    pages_used;
    logic                          buf_full;
    logic                          page_freed;

    hist_regs regs_i (
        .mclk, .nreset_aclk, .reg_wr, .mode, .start_page
    );

    hist_arbiter arbiter_i (
        .mclk, .nreset_aclk, .en(mode.en), .src, .buf_full, .page_done,
        .grant, .sel_src, .sel_idx
    );

    hist_page_writer writer_i (
        .mclk, .nreset_aclk, .en(mode.en), .sel_src, .sel_idx,
        .wr_en, .wr_addr, .wr_data, .page_done, .attr_push, .attr(attr_in)
    );

    hist_fifo #(
        .T     (hist_attr_t),
        .DEPTH (`HIST_NUM_PAGES)    // one attribute per buffer page
    ) attr_fifo_i (
        .mclk, .nreset_aclk, .clear(!mode.en), .push(attr_push), .din(attr_in),
        .pop(attr_pop), .dout(attr_out), .nempty(attr_nempty), .half_full()
    );

    hist_page_buffer buffer_i (
        .mclk, .nreset_aclk, .en(mode.en), .wr_en, .wr_addr, .wr_data,
        .page_done, .page_freed, .rd_en, .rd_addr, .rd_data, .pages_used, .buf_full
    );

    hist_axi_sender sender_i (
        .mclk, .nreset_aclk, .mode, .start_page, .pages_used,
        .attr(attr_out), .attr_nempty, .attr_pop, .rd_en, .rd_addr, .rd_data,
        .page_freed, .aw, .awvalid, .awready, .w, .wvalid, .wready, .bvalid
    );

endmodule

`default_nettype wire

// File: tb_hist_saxi.sv
// directed testbench for the histogram page transfer block
// drives the four sensor sources and the register port, models the AXI slave
// side and checks address, id, data and wlast of every page on the bus
`timescale 1ns/1ps
`default_nettype none
`include "hist_defs.svh"

module tb_hist_saxi;
    import hist_pkg::*;

    localparam int PAGE_TO = 4000;                                 // cycles allowed per wait
    localparam int NB      = `HIST_PAGE_WORDS / `HIST_BURST_LEN;   // bursts per page

    logic                     mclk;
    logic                     nreset_aclk;
    reg_wr_t                  reg_wr;
    hist_src_t                src [`HIST_NUM_SRC];
    logic [`HIST_NUM_SRC-1:0] grant;
    axi_aw_t                  aw;
    logic                     awvalid;
    logic                     awready;
    axi_w_t                   w;
    logic                     wvalid;
    logic                     wready;
    logic                     bvalid;

    integer      seed        = 32'h5413;
    logic [31:0] rnd;
    logic        aw_stall_en = 1'b0;     // random awready stalls
    logic        w_stall_en  = 1'b0;     // random wready stalls
    logic        w_hold      = 1'b0;     // wready forced low
    logic        b_hold      = 1'b0;     // responses withheld
    int          b_delay     = 2;        // idle cycles before each response
    logic        fifth_done  = 1'b0;

    logic [`HIST_START_PAGE_W-1:0] start_tbl [`HIST_NUM_SRC];   // copy of the table written
    logic [31:0] aw_addr_q [$];
    logic [3:0]  aw_id_q [$];
    int          aw_b_q [$];             // responses seen when each burst was addressed
    logic [31:0] w_data_q [$];
    logic        w_last_q [$];
    int          aw_cnt    = 0;
    int          wl_cnt    = 0;
    int          b_seen    = 0;
    int          b_sent    = 0;
    int          grant_cnt = 0;
    logic [`HIST_NUM_SRC-1:0] grant_r = '0;
    int          mismatches = 0;
    int          failures   = 0;

    hist_saxi_top UUT (
        .mclk, .nreset_aclk, .reg_wr, .src, .grant,
        .aw, .awvalid, .awready, .w, .wvalid, .wready, .bvalid
    );

    initial begin
        mclk = 1'b0;
        forever #50 mclk = ~mclk;        // 100 ns period
    end

    // slave ready lines, changed on the falling edge
    initial begin
        awready = 1'b0;
        wready  = 1'b0;
        forever begin
            @(negedge mclk);
            rnd = $random(seed);
            awready <= !(aw_stall_en && rnd[1:0] == 2'b00);        // 1 in 4 stalls
            wready  <= !w_hold && !(w_stall_en && rnd[3:2] == 2'b00);
        end
    end

    // one response per burst once both its address and its wlast were seen
    initial begin
        int wait_cnt;
        wait_cnt = 0;
        bvalid   = 1'b0;
        forever begin
            @(negedge mclk);
            bvalid <= 1'b0;
            if (!b_hold && b_sent < (aw_cnt < wl_cnt ? aw_cnt : wl_cnt)) begin
                if (wait_cnt >= b_delay) begin
                    bvalid   <= 1'b1;
                    b_sent   = b_sent + 1;
                    wait_cnt = 0;
                end else begin
                    wait_cnt = wait_cnt + 1;
                end
            end
        end
    end

    // bus monitor, transfers taken on the rising edge
    always @(posedge mclk) begin
        if (awvalid && awready) begin
            aw_addr_q.push_back(aw.addr);
            aw_id_q.push_back(aw.id);
            aw_b_q.push_back(b_seen);
            aw_cnt = aw_cnt + 1;
        end
        if (wvalid && wready) begin
            w_data_q.push_back(w.data);
            w_last_q.push_back(w.last);
            if (w.last) wl_cnt = wl_cnt + 1;
        end
        if (bvalid) b_seen = b_seen + 1;
        if ((|grant) && !(|grant_r)) grant_cnt = grant_cnt + 1;    // new grant
        grant_r = grant;
    end

    task automatic check_val(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic report_fail(input string msg);
        failures++;
        $display("ERROR at %0t ns: %s", $time, msg);
    endtask

    // known page content: source, frame and word index
    function automatic logic [31:0] page_word(input int s, input int frame, input int n);
        return {4'hA, 4'(s), 8'(frame), 16'(n)};
    endfunction

    task automatic reg_write(input logic [3:0] addr, input logic [31:0] data);
        @(negedge mclk);
        reg_wr.valid = 1'b1;
        reg_wr.addr  = addr;
        reg_wr.data  = data;
        @(negedge mclk);
        reg_wr.valid = 1'b0;
    endtask

    task automatic set_mode(input bit en, input bit confirm);
        reg_write(4'(`HIST_REG_MODE),
                  (32'(en) << `HIST_MODE_EN) | (32'(confirm) << `HIST_MODE_CONFIRM));
    endtask

    task automatic send_page(input int s, input int color, input int frame);
        int t;
        int n;
        @(negedge mclk);
        src[s].request = 1'b1;
        src[s].color   = 2'(color);
        src[s].frame   = 4'(frame);
        t = 0;
        while (!grant[s] && t < PAGE_TO) begin
            @(negedge mclk);
            t++;
        end
        src[s].request = 1'b0;
        if (!grant[s]) begin
            report_fail($sformatf("source %0d never got a grant", s));
            return;
        end
        for (n = 0; n < `HIST_PAGE_WORDS; n++) begin    // one word per cycle
            src[s].dvalid = 1'b1;
            src[s].data   = page_word(s, frame, n);
            @(negedge mclk);
        end
        src[s].dvalid = 1'b0;                           // page end
    endtask

    // pops one page from the monitor queues and compares it
    task automatic check_page(input int s, input int color, input int frame, output int b_first);
        int          t;
        int          k;
        int          n;
        logic [31:0] base;
        b_first = 0;
        t = 0;
        while ((aw_addr_q.size() < NB || w_data_q.size() < `HIST_PAGE_WORDS) && t < PAGE_TO) begin
            @(negedge mclk);
            t++;
        end
        if (aw_addr_q.size() < NB || w_data_q.size() < `HIST_PAGE_WORDS) begin
            report_fail($sformatf("page of source %0d frame %0d did not arrive", s, frame));
            return;
        end
        base    = ((32'(start_tbl[s]) + 32'(frame)) << 12) + (32'(color) << 10);
        b_first = aw_b_q[0];
        for (k = 0; k < NB; k++) begin
            check_val($sformatf("awaddr src %0d burst %0d", s, k),
                      aw_addr_q.pop_front(), base + 32'(64 * k));
            check_val($sformatf("awid src %0d burst %0d", s, k),
                      32'(aw_id_q.pop_front()), 32'({2'(s), 2'(color)}));
            void'(aw_b_q.pop_front());
        end
        for (n = 0; n < `HIST_PAGE_WORDS; n++) begin
            check_val($sformatf("wdata src %0d word %0d", s, n),
                      w_data_q.pop_front(), page_word(s, frame, n));
            check_val($sformatf("wlast src %0d word %0d", s, n), 32'(w_last_q.pop_front()),
                      32'((n % `HIST_BURST_LEN) == `HIST_BURST_LEN - 1));
        end
    endtask

    // all bursts answered and nothing left unchecked
    task automatic wait_idle();
        int t;
        t = 0;
        while ((b_seen != aw_cnt || wl_cnt != aw_cnt) && t < PAGE_TO) begin
            @(negedge mclk);
            t++;
        end
        if (b_seen != aw_cnt || wl_cnt != aw_cnt)
            report_fail("bus did not settle, bursts left without response");
        if (aw_addr_q.size() != 0 || w_data_q.size() != 0)
            report_fail("bus carried more transfers than the pages sent");
    endtask

    task automatic test_single_page();
        int i;
        int b_first;
        for (i = 0; i < `HIST_NUM_SRC; i++) begin
            start_tbl[i] = 20'(32'h0_8000 + 32'(i) * 32'h140);   // distinct regions
            reg_write(4'(`HIST_REG_START0 + i), 32'(start_tbl[i]));
        end
        set_mode(1'b1, 1'b0);
        send_page(2, 1, 3);
        check_page(2, 1, 3, b_first);
        wait_idle();
    endtask

    task automatic test_priority();
        int b_first;
        fork
            send_page(3, 0, 7);
            send_page(1, 2, 6);
        join
        check_page(1, 2, 6, b_first);   // lower index first
        check_page(3, 0, 7, b_first);
        wait_idle();
    endtask

    task automatic test_backpressure();
        int t;
        int g0;
        int b_first;
        aw_stall_en = 1'b1;
        w_stall_en  = 1'b1;
        w_hold      = 1'b1;
        g0          = grant_cnt;
        fork
            send_page(0, 0, 1);
            send_page(1, 1, 2);
            send_page(2, 2, 3);
            send_page(3, 3, 4);
        join
        fifth_done = 1'b0;
        fork
            begin
                send_page(0, 1, 5);             // buffer is full, waits for a free page
                fifth_done = 1'b1;
            end
        join_none
        repeat (50) @(negedge mclk);            // window where no fifth grant may appear
        if (grant_cnt - g0 > 4)
            report_fail("more than four grants while wready was held low");
        w_hold = 1'b0;
        t = 0;
        while (!fifth_done && t < PAGE_TO) begin
            @(negedge mclk);
            t++;
        end
        if (!fifth_done) report_fail("fifth page was never sent by its source");
        check_page(0, 0, 1, b_first);
        check_page(1, 1, 2, b_first);
        check_page(2, 2, 3, b_first);
        check_page(3, 3, 4, b_first);
        check_page(0, 1, 5, b_first);
        aw_stall_en = 1'b0;
        w_stall_en  = 1'b0;
        wait_idle();
    endtask

    task automatic test_confirm();
        int b0;
        int b_first;
        b0     = b_seen;
        b_hold = 1'b1;
        set_mode(1'b1, 1'b1);
        fork
            send_page(0, 2, 8);
            send_page(1, 3, 9);
        join
        check_page(0, 2, 8, b_first);
        repeat (100) @(negedge mclk);           // second page must stay off the bus
        if (aw_addr_q.size() != 0)
            report_fail("second page addressed before the first page's responses");
        b_delay = 3;
        b_hold  = 1'b0;
        check_page(1, 3, 9, b_first);
        if (b_first - b0 < NB)
            report_fail("second page addressed after fewer than sixteen responses");
        wait_idle();
        b_delay = 2;
        set_mode(1'b1, 1'b0);
    endtask

    task automatic test_disable();
        int  t;
        int  b_first;
        bit  bad_grant;
        bit  bad_bus;
        bad_grant = 1'b0;
        bad_bus   = 1'b0;
        set_mode(1'b0, 1'b0);
        @(negedge mclk);
        src[2].request = 1'b1;
        src[2].color   = 2'd3;
        src[2].frame   = 4'd9;
        for (t = 0; t < 100; t++) begin         // observation window while disabled
            @(negedge mclk);
            if (grant != '0) bad_grant = 1'b1;
            if (awvalid || wvalid) bad_bus = 1'b1;
        end
        if (bad_grant) report_fail("grant raised while transfers were disabled");
        if (bad_bus) report_fail("awvalid or wvalid raised while transfers were disabled");
        set_mode(1'b1, 1'b0);
        send_page(2, 3, 9);                     // request still pending
        check_page(2, 3, 9, b_first);
        wait_idle();
    endtask

    initial begin
        int i;
        reg_wr      = '0;
        nreset_aclk = 1'b0;
        for (i = 0; i < `HIST_NUM_SRC; i++) begin
            src[i]       = '0;
            start_tbl[i] = '0;
        end
        repeat (5) @(posedge mclk);
        @(negedge mclk);
        nreset_aclk = 1'b1;

        test_single_page();
        test_priority();
        test_backpressure();
        test_confirm();
        test_disable();

        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
